//--- Makefile
# Verilator build for the SPI to video project
# usage: make compile | make run | make clean
# variables can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_spi_video
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
EXTRA     ?=

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# $fatal in the testbench gives a non-zero exit, so make fails with it
run: compile
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/pixel_assembler.sv
////////////////////
// packs red, green, blue bytes into one pixel
// no resync, phase only returns to red after blue
////////////////////

`timescale 1ns/1ps

module pixel_assembler (
    input  logic                           i_clk_74a,
    input  logic                           i_reset_n,
    input  logic [spi_pkg::SPI_BYTE_W-1:0] i_byte,
    input  logic                           i_byte_valid,
    output video_pkg::rgb_t                o_pixel
);

    spi_pkg::byte_phase_e phase_q;

    // staging for the first two colours
    logic [spi_pkg::SPI_BYTE_W-1:0] red_q;
    logic [spi_pkg::SPI_BYTE_W-1:0] green_q;

    ////////////////////
    // phase and commit
    ////////////////////

    always_ff @(posedge i_clk_74a or negedge i_reset_n) begin
        if (!i_reset_n) begin
            phase_q <= spi_pkg::PH_RED;
            o_pixel <= '0;
        end else if (i_byte_valid) begin
            case (phase_q)
                spi_pkg::PH_RED: begin
                    phase_q <= spi_pkg::PH_GREEN;
                end
                spi_pkg::PH_GREEN: begin
                    phase_q <= spi_pkg::PH_BLUE;
                end
                spi_pkg::PH_BLUE: begin
                    // whole pixel at once, no half-updated colour
                    o_pixel.r <= red_q;
                    o_pixel.g <= green_q;
                    o_pixel.b <= i_byte;
                    phase_q   <= spi_pkg::PH_RED;
                end
                default: begin
                    phase_q <= spi_pkg::PH_RED;
                end
            endcase
        end
    end

    // staging capture
    always_ff @(posedge i_clk_74a) begin
        if (i_byte_valid && phase_q == spi_pkg::PH_RED) begin
            red_q <= i_byte;
        end
        if (i_byte_valid && phase_q == spi_pkg::PH_GREEN) begin
            green_q <= i_byte;
        end
    end

    a_phase_legal : assert property (
        @(posedge i_clk_74a) disable iff (!i_reset_n)
        phase_q inside {spi_pkg::PH_RED, spi_pkg::PH_GREEN, spi_pkg::PH_BLUE}
    );

endmodule

//--- rtl/spi_byte_receiver.sv
////////////////////
// spi mode 0 byte receiver, receive only
// pins are asynchronous, each sck phase needs >= 4 clk_74a cycles
// byte_valid comes 3 clk_74a cycles after the 8th rising sck
// cs_n high drops any partial byte
////////////////////

`timescale 1ns/1ps

module spi_byte_receiver (
    input  logic                          i_clk_74a,
    input  logic                          i_reset_n,
    input  logic                          i_spi_sck,
    input  logic                          i_spi_mosi,
    input  logic                          i_spi_cs_n,
    output logic [spi_pkg::SPI_BYTE_W-1:0] o_byte,
    output logic                          o_byte_valid
);

    localparam int CNT_W = $clog2(spi_pkg::SPI_BYTE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(spi_pkg::SPI_BYTE_W - 1);

    ////////////////////
    // synchronizers
    ////////////////////

    logic sck_meta;
    logic sck_sync;
    logic sck_prev;
    logic mosi_meta;
    logic mosi_sync;
    logic cs_n_meta;
    logic cs_n_sync;
    logic sck_rise;

    always_ff @(posedge i_clk_74a or negedge i_reset_n) begin
        if (!i_reset_n) begin
            sck_meta  <= 1'b0;
            sck_sync  <= 1'b0;
            sck_prev  <= 1'b0;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
            // idle as deselected
            cs_n_meta <= 1'b1;
            cs_n_sync <= 1'b1;
        end else begin
            sck_meta  <= i_spi_sck;
            sck_sync  <= sck_meta;
            // third stage, only for edge detect
            sck_prev  <= sck_sync;
            mosi_meta <= i_spi_mosi;
            mosi_sync <= mosi_meta;
            cs_n_meta <= i_spi_cs_n;
            cs_n_sync <= cs_n_meta;
        end
    end

    // mosi_sync lines up with sck_sync, so sample it here
    assign sck_rise = sck_sync & ~sck_prev;

    ////////////////////
    // bit counter
    ////////////////////

    logic [CNT_W-1:0]               bit_cnt_q;
    logic [spi_pkg::SPI_BYTE_W-1:0] shift_q;

    always_ff @(posedge i_clk_74a or negedge i_reset_n) begin
        if (!i_reset_n) begin
            bit_cnt_q    <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            if (cs_n_sync) begin
                // deselected, restart at bit 0
                bit_cnt_q <= '0;
            end else if (sck_rise) begin
                // counter wraps to 0 after the last bit
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (bit_cnt_q == LAST_BIT) begin
                    o_byte_valid <= 1'b1;
                end
            end
        end
    end

    // shift in msb first
    always_ff @(posedge i_clk_74a) begin
        if (sck_rise && !cs_n_sync) begin
            shift_q <= {shift_q[spi_pkg::SPI_BYTE_W-2:0], mosi_sync};
        end
    end

    // shift_q holds the full byte until the next sck edge, >= 8 cycles later
    assign o_byte = shift_q;

    // strobe, never a level
    a_valid_single : assert property (
        @(posedge i_clk_74a) disable iff (!i_reset_n)
        o_byte_valid |=> !o_byte_valid
    );

endmodule

//--- rtl/spi_pkg.sv
////////////////////
// serial byte width and assembler phase
// phase order is fixed: red, green, blue
////////////////////

package spi_pkg;

    // bits per spi byte, msb first on the wire
    localparam int SPI_BYTE_W = 8;

    // bytes that make one pixel
    localparam int BYTES_PER_PIXEL = 3;

    // which colour the next byte carries
    typedef enum logic [$clog2(BYTES_PER_PIXEL)-1:0] {
        PH_RED,
        PH_GREEN,
        PH_BLUE
    } byte_phase_e;

endpackage

//--- rtl/spi_video_top.sv
////////////////////
// spi rgb stream to video, all on clk_74a
// a pixel shows at the next de period after its blue byte
// spi pins are asynchronous, mode 0
////////////////////

`timescale 1ns/1ps

module spi_video_top #(
    parameter int H_TOTAL   = video_pkg::H_TOTAL_DEF,
    parameter int H_ACTIVE  = video_pkg::H_ACTIVE_DEF,
    parameter int H_BPORCH  = video_pkg::H_BPORCH_DEF,
    parameter int V_TOTAL   = video_pkg::V_TOTAL_DEF,
    parameter int V_ACTIVE  = video_pkg::V_ACTIVE_DEF,
    parameter int V_BPORCH  = video_pkg::V_BPORCH_DEF,
    parameter int PIXEL_DIV = video_pkg::PIXEL_DIV_DEF
) (
    input  logic            i_clk_74a,
    input  logic            i_reset_n,
    input  logic            i_spi_sck,
    input  logic            i_spi_mosi,
    input  logic            i_spi_cs_n,
    output video_pkg::rgb_t o_video_rgb,
    output logic            o_video_de,
    output logic            o_video_vs,
    output logic            o_video_hs,
    output logic            o_pixel_ce
);

    // receiver to assembler
    logic [spi_pkg::SPI_BYTE_W-1:0] spi_byte;
    logic                           spi_byte_valid;

    // assembler to timing, last complete pixel
    video_pkg::rgb_t pixel;

    spi_byte_receiver u_rx (
        .i_clk_74a    (i_clk_74a),
        .i_reset_n    (i_reset_n),
        .i_spi_sck    (i_spi_sck),
        .i_spi_mosi   (i_spi_mosi),
        .i_spi_cs_n   (i_spi_cs_n),
        .o_byte       (spi_byte),
        .o_byte_valid (spi_byte_valid)
    );

    pixel_assembler u_asm (
        .i_clk_74a    (i_clk_74a),
        .i_reset_n    (i_reset_n),
        .i_byte       (spi_byte),
        .i_byte_valid (spi_byte_valid),
        .o_pixel      (pixel)
    );

    video_timing #(
        .H_TOTAL   (H_TOTAL),
        .H_ACTIVE  (H_ACTIVE),
        .H_BPORCH  (H_BPORCH),
        .V_TOTAL   (V_TOTAL),
        .V_ACTIVE  (V_ACTIVE),
        .V_BPORCH  (V_BPORCH),
        .PIXEL_DIV (PIXEL_DIV)
    ) u_timing (
        .i_clk_74a   (i_clk_74a),
        .i_reset_n   (i_reset_n),
        .i_pixel     (pixel),
        .o_video_rgb (o_video_rgb),
        .o_video_de  (o_video_de),
        .o_video_vs  (o_video_vs),
        .o_video_hs  (o_video_hs),
        .o_pixel_ce  (o_pixel_ce)
    );

endmodule

//--- rtl/video_pkg.sv
////////////////////
// raster defaults and the pixel type
// defaults give 320x240 active inside a 400x512 total
// counters are COUNT_W wide, so totals stay below 1024
////////////////////

package video_pkg;

    // red high byte, then green, then blue
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // horizontal raster, in pixel periods
    localparam int H_TOTAL_DEF  = 400;
    localparam int H_ACTIVE_DEF = 320;
    localparam int H_BPORCH_DEF = 10;

    // vertical raster, in lines
    localparam int V_TOTAL_DEF  = 512;
    localparam int V_ACTIVE_DEF = 240;
    localparam int V_BPORCH_DEF = 10;

    // clk_74a cycles per pixel
    localparam int PIXEL_DIV_DEF = 6;

    // hs column, a few pixels after vs
    localparam int HS_OFFSET = 3;

    localparam int COUNT_W = 10;

endpackage

//--- rtl/video_timing.sv
////////////////////
// raster timing on clk_74a with a pixel strobe
// outputs change the cycle after o_pixel_ce and hold for PIXEL_DIV cycles
// vs at x=0 y=0, hs at x=HS_OFFSET, black outside the active window
////////////////////

`timescale 1ns/1ps

module video_timing #(
    parameter int H_TOTAL   = video_pkg::H_TOTAL_DEF,
    parameter int H_ACTIVE  = video_pkg::H_ACTIVE_DEF,
    parameter int H_BPORCH  = video_pkg::H_BPORCH_DEF,
    parameter int V_TOTAL   = video_pkg::V_TOTAL_DEF,
    parameter int V_ACTIVE  = video_pkg::V_ACTIVE_DEF,
    parameter int V_BPORCH  = video_pkg::V_BPORCH_DEF,
    parameter int PIXEL_DIV = video_pkg::PIXEL_DIV_DEF
) (
    input  logic            i_clk_74a,
    input  logic            i_reset_n,
    input  video_pkg::rgb_t i_pixel,
    output video_pkg::rgb_t o_video_rgb,
    output logic            o_video_de,
    output logic            o_video_vs,
    output logic            o_video_hs,
    output logic            o_pixel_ce
);

    localparam int CW    = video_pkg::COUNT_W;
    localparam int DIV_W = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(PIXEL_DIV - 1);
    localparam logic [CW-1:0]    X_LAST   = CW'(H_TOTAL - 1);
    localparam logic [CW-1:0]    Y_LAST   = CW'(V_TOTAL - 1);
    localparam logic [CW-1:0]    X_START  = CW'(H_BPORCH);
    localparam logic [CW-1:0]    X_END    = CW'(H_BPORCH + H_ACTIVE);
    localparam logic [CW-1:0]    Y_START  = CW'(V_BPORCH);
    localparam logic [CW-1:0]    Y_END    = CW'(V_BPORCH + V_ACTIVE);
    localparam logic [CW-1:0]    HS_COL   = CW'(video_pkg::HS_OFFSET);

    ////////////////////
    // pixel strobe
    ////////////////////

    logic [DIV_W-1:0] div_q;

    always_ff @(posedge i_clk_74a or negedge i_reset_n) begin
        if (!i_reset_n) begin
            div_q      <= '0;
            o_pixel_ce <= 1'b0;
        end else if (div_q == DIV_LAST) begin
            div_q      <= '0;
            o_pixel_ce <= 1'b1;
        end else begin
            div_q      <= div_q + 1'b1;
            o_pixel_ce <= 1'b0;
        end
    end

    ////////////////////
    // counters and decode
    ////////////////////

    logic [CW-1:0] x_q;
    logic [CW-1:0] y_q;
    logic          in_window;

    // active window for the current position
    assign in_window = (x_q >= X_START) && (x_q < X_END) &&
                       (y_q >= Y_START) && (y_q < Y_END);

    always_ff @(posedge i_clk_74a or negedge i_reset_n) begin
        if (!i_reset_n) begin
            x_q         <= '0;
            y_q         <= '0;
            o_video_de  <= 1'b0;
            o_video_vs  <= 1'b0;
            o_video_hs  <= 1'b0;
            o_video_rgb <= '0;
        end else if (o_pixel_ce) begin
            // advance, wrap at the totals
            if (x_q == X_LAST) begin
                x_q <= '0;
                y_q <= (y_q == Y_LAST) ? '0 : y_q + 1'b1;
            end else begin
                x_q <= x_q + 1'b1;
            end
            // outputs follow the position before the advance
            o_video_vs  <= (x_q == '0) && (y_q == '0);
            o_video_hs  <= (x_q == HS_COL);
            o_video_de  <= in_window;
            // black outside the window
            o_video_rgb <= in_window ? i_pixel : '0;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    initial begin
        a_h_fits : assert (H_BPORCH + H_ACTIVE <= H_TOTAL);
        a_v_fits : assert (V_BPORCH + V_ACTIVE <= V_TOTAL);
        a_hs_col : assert (video_pkg::HS_OFFSET < H_TOTAL);
    end

    // vs sits in the back porch, never on an active pixel
    a_de_vs_excl : assert property (
        @(posedge i_clk_74a) disable iff (!i_reset_n)
        !(o_video_de && o_video_vs)
    );

endmodule

//--- tb/tb_spi_video_table.svh
////////////////////
// pixel table and lfsr for tb_spi_video, included inside the module
// columns: bytes sent (red, green, blue), mid-byte cs_n release, expected pixel
// bytes go out red first, msb first
////////////////////

`ifndef TB_SPI_VIDEO_TABLE_SVH
`define TB_SPI_VIDEO_TABLE_SVH

localparam int NUM_ROWS   = 6;
localparam int NUM_RANDOM = 4;

// stray bits sent ahead of a cs_n release
localparam int         PARTIAL_BITS    = 5;
localparam logic [4:0] PARTIAL_PATTERN = 5'b11011;

// bytes on the wire, red in the top byte
localparam logic [23:0] ROW_BYTES [NUM_ROWS] = '{
    24'h123456, 24'hff0080, 24'ha55ac3,
    24'h010203, 24'hfedcba, 24'h80017f
};

// cs_n released mid byte ahead of the row
localparam logic ROW_CS_BREAK [NUM_ROWS] = '{
    1'b0, 1'b0, 1'b0,
    1'b1, 1'b1, 1'b0
};

// pixel on the next de period, stray bits gone
localparam logic [23:0] ROW_EXPECT [NUM_ROWS] = '{
    24'h123456, 24'hff0080, 24'ha55ac3,
    24'h010203, 24'hfedcba, 24'h80017f
};

localparam logic [31:0] LFSR_SEED = 32'h89454d48;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_advance(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

`endif

//--- tb/tb_spi_video.sv
////////////////////
// testbench for spi_video_top with a small raster
// inputs change on the falling edge, outputs sampled there too
// each sck phase lasts SCK_HALF clk_74a cycles
////////////////////

`timescale 1ns/1ps

module tb_spi_video;

    // small raster, one frame is a few hundred cycles
    localparam int H_TOTAL   = 20;
    localparam int H_ACTIVE  = 8;
    localparam int H_BPORCH  = 4;
    localparam int V_TOTAL   = 12;
    localparam int V_ACTIVE  = 4;
    localparam int V_BPORCH  = 2;
    localparam int PIXEL_DIV = 2;
    localparam int HS_OFFSET = 3;

    localparam int SCK_HALF     = 4;
    localparam int BYTE_CYCLES  = 8 * 2 * SCK_HALF;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * PIXEL_DIV;

    `include "tb_spi_video_table.svh"

    // per row: 24 bytes of spi time plus two frames, margin for reset and raster
    localparam int TOTAL_ROWS  = NUM_ROWS + NUM_RANDOM;
    localparam int CYCLE_LIMIT =
        TOTAL_ROWS * (24 * BYTE_CYCLES + 2 * FRAME_CYCLES) + 4 * FRAME_CYCLES;

    logic        clk_74a;
    logic        reset_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_cs_n;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;
    logic        pixel_ce;
    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    spi_video_top #(
        .H_TOTAL   (H_TOTAL),
        .H_ACTIVE  (H_ACTIVE),
        .H_BPORCH  (H_BPORCH),
        .V_TOTAL   (V_TOTAL),
        .V_ACTIVE  (V_ACTIVE),
        .V_BPORCH  (V_BPORCH),
        .PIXEL_DIV (PIXEL_DIV)
    ) i_dut (
        .i_clk_74a   (clk_74a),
        .i_reset_n   (reset_n),
        .i_spi_sck   (spi_sck),
        .i_spi_mosi  (spi_mosi),
        .i_spi_cs_n  (spi_cs_n),
        .o_video_rgb (video_rgb),
        .o_video_de  (video_de),
        .o_video_vs  (video_vs),
        .o_video_hs  (video_hs),
        .o_pixel_ce  (pixel_ce)
    );

    initial clk_74a = 1'b0;
    always #5 clk_74a = ~clk_74a;

    // watchdog
    always @(posedge clk_74a) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d clock cycles", cycle_count);
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic report_error(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic expect_quiet(input string where);
        assert (!video_de && !video_vs && !video_hs && video_rgb == 24'h0)
            else report_error($sformatf("%s: de %b vs %b hs %b rgb %06h, expected all low",
                                        where, video_de, video_vs, video_hs, video_rgb));
    endtask

    // returns one cycle after a strobe, when outputs hold the new period
    task automatic next_period();
        @(negedge clk_74a);
        while (!pixel_ce) @(negedge clk_74a);
        @(negedge clk_74a);
    endtask

    ////////////////////
    // spi driver
    ////////////////////

    task automatic send_bit(input logic value);
        spi_sck  = 1'b0;
        spi_mosi = value;
        repeat (SCK_HALF) @(negedge clk_74a);
        spi_sck = 1'b1;
        repeat (SCK_HALF) @(negedge clk_74a);
    endtask

    task automatic send_byte(input logic [7:0] value);
        for (int b = 7; b >= 0; b--) begin
            send_bit(value[b]);
        end
    endtask

    task automatic select_slave();
        spi_cs_n = 1'b0;
        repeat (SCK_HALF) @(negedge clk_74a);
    endtask

    task automatic release_slave();
        spi_sck = 1'b0;
        repeat (SCK_HALF) @(negedge clk_74a);
        spi_cs_n = 1'b1;
        repeat (2 * SCK_HALF) @(negedge clk_74a);
    endtask

    task automatic send_row(input logic [23:0] pixel_bytes, input logic cs_break);
        select_slave();
        if (cs_break) begin
            // stray bits, dropped by the cs_n release
            for (int k = 0; k < PARTIAL_BITS; k++) begin
                send_bit(PARTIAL_PATTERN[PARTIAL_BITS - 1 - k]);
            end
            release_slave();
            select_slave();
        end
        for (int k = 0; k < 3; k++) begin
            send_byte(pixel_bytes[23 - 8 * k -: 8]);
        end
        release_slave();
    endtask

    task automatic take_random_byte(output logic [7:0] value);
        value = 8'h00;
        // one lfsr step per bit
        for (int b = 0; b < 8; b++) begin
            lfsr_state = lfsr_advance(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    ////////////////////
    // checks
    ////////////////////

    // one full frame with a non-black pixel loaded
    task automatic verify_raster(input logic [23:0] shown);
        int vs_count;
        int hs_count;
        int de_count;
        int first_hs;
        int start_cycle;
        vs_count    = 0;
        hs_count    = 0;
        de_count    = 0;
        first_hs    = -1;
        start_cycle = 0;
        // align on the vs period
        next_period();
        while (!video_vs) next_period();
        start_cycle = cycle_count;
        for (int idx = 0; idx < H_TOTAL * V_TOTAL; idx++) begin
            if (idx > 0) begin
                next_period();
            end
            if (video_vs) begin
                vs_count++;
            end
            if (video_hs) begin
                hs_count++;
                if (first_hs < 0) begin
                    first_hs = idx;
                end
            end
            if (video_de) begin
                de_count++;
                assert (video_rgb == shown)
                    else report_error($sformatf("rgb %06h with de high, expected %06h",
                                                video_rgb, shown));
            end else begin
                assert (video_rgb == 24'h0)
                    else report_error($sformatf("rgb %06h with de low", video_rgb));
            end
        end
        // strobe spacing, PIXEL_DIV cycles per pixel period
        assert (cycle_count - start_cycle == (H_TOTAL * V_TOTAL - 1) * PIXEL_DIV)
            else report_error($sformatf("frame took %0d cycles, expected %0d",
                                        cycle_count - start_cycle,
                                        (H_TOTAL * V_TOTAL - 1) * PIXEL_DIV));
        assert (vs_count == 1)
            else report_error($sformatf("%0d vs periods per frame, expected 1", vs_count));
        assert (hs_count == V_TOTAL)
            else report_error($sformatf("%0d hs periods per frame, expected %0d",
                                        hs_count, V_TOTAL));
        assert (de_count == H_ACTIVE * V_ACTIVE)
            else report_error($sformatf("%0d de periods per frame, expected %0d",
                                        de_count, H_ACTIVE * V_ACTIVE));
        assert (first_hs == HS_OFFSET)
            else report_error($sformatf("hs %0d strobes after vs, expected %0d",
                                        first_hs, HS_OFFSET));
    endtask

    task automatic check_next_pixel(input int row, input logic [23:0] expected);
        logic found;
        found = 1'b0;
        while (!found) begin
            next_period();
            if (video_de) begin
                found = 1'b1;
                assert (video_rgb == expected)
                    else report_error($sformatf("row %0d: rgb %06h, expected %06h",
                                                row, video_rgb, expected));
            end else begin
                assert (video_rgb == 24'h0)
                    else report_error($sformatf("row %0d: rgb %06h with de low",
                                                row, video_rgb));
            end
        end
    endtask

    initial begin : stimulus
        logic [23:0] pixel_bytes;
        logic [23:0] expected;
        logic        cs_break;
        logic [7:0]  red;
        logic [7:0]  green;
        logic [7:0]  blue;
        reset_n    = 1'b0;
        spi_sck    = 1'b0;
        spi_mosi   = 1'b0;
        spi_cs_n   = 1'b1;
        lfsr_state = LFSR_SEED;
        expected   = 24'h0;

        repeat (8) begin
            @(negedge clk_74a);
            expect_quiet("in reset");
            assert (!pixel_ce) else report_error("pixel strobe high in reset");
        end
        reset_n = 1'b1;
        // quiet up to and including the first strobe
        expect_quiet("after reset");
        while (!pixel_ce) begin
            @(negedge clk_74a);
            expect_quiet("before first strobe");
        end

        for (int row = 0; row < TOTAL_ROWS; row++) begin
            if (row < NUM_ROWS) begin
                pixel_bytes = ROW_BYTES[row];
                cs_break    = ROW_CS_BREAK[row];
                expected    = ROW_EXPECT[row];
            end else begin
                take_random_byte(red);
                take_random_byte(green);
                take_random_byte(blue);
                pixel_bytes = {red, green, blue};
                cs_break    = 1'b0;
                // red high byte, then green, then blue
                expected    = {red, green, blue};
            end
            send_row(pixel_bytes, cs_break);
            check_next_pixel(row, expected);
        end

        // last pixel stays on screen for the raster pass
        verify_raster(expected);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tb
rtl/video_pkg.sv
rtl/spi_pkg.sv
rtl/spi_byte_receiver.sv
rtl/pixel_assembler.sv
rtl/video_timing.sv
rtl/spi_video_top.sv
tb/tb_spi_video.sv
